/* source/core_cfg.svh */
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Data and address width
`define CORE_XLEN 32

// Architectural register file
`define CORE_REG_COUNT 32
`define CORE_REG_IDX_W 5

// Immediate field widths (I and S share one)
`define CORE_IMM_I_W 12
`define CORE_IMM_U_W 20

// Bytes per word and PC step
`define CORE_BYTE_LANES 4
`define CORE_INSTR_BYTES 4

`endif

/* source/core_pkg.sv */
`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_XLEN-1:0] word_t;
    typedef logic [`CORE_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`CORE_BYTE_LANES-1:0] byte_mask_t;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [5:0] {
        OP_NONE,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW
    } op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } r_fields_t;

    typedef struct packed {
        logic [`CORE_IMM_I_W-1:0] imm;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
    } i_fields_t;

    // Store immediate is split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fields_t;

    typedef struct packed {
        logic [`CORE_IMM_U_W-1:0] imm;
        reg_idx_t   rd;
        opcode_e    opcode;
    } u_fields_t;

    typedef union packed {
        word_t     raw;
        r_fields_t r;
        i_fields_t i;
        s_fields_t s;
        u_fields_t u;
    } rv32i_instr_u;

    typedef struct packed {
        op_e      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     is_load;
        logic     is_store;
        logic     writes_rd;
    } decoded_t;

    typedef struct packed {
        logic       valid;
        word_t      addr;
        byte_mask_t do_read;
        byte_mask_t do_write;
        word_t      wdata;
    } mem_req_t;

    typedef struct packed {
        logic  valid;
        word_t data;
    } mem_rsp_t;

endpackage

/* source/core_control.sv */
`include "core_cfg.svh"

module core_control import core_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  word_t        i_reset_pc,
    input  mem_rsp_t     i_instr_mem_rsp,
    input  decoded_t     i_decoded,
    input  word_t        i_exec_result,
    input  mem_rsp_t     i_data_mem_rsp,
    input  word_t        i_load_data,
    output mem_req_t     o_instr_mem_req,
    output rv32i_instr_u o_instr,
    output word_t        o_pc,
    output word_t        o_result,
    output logic         o_mem_stage,
    output reg_idx_t     o_wb_idx,
    output word_t        o_wb_data,
    output logic         o_wb_en
);

    typedef enum logic [2:0] {
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_MEM,
        STAGE_WRITEBACK
    } stage_e;

    stage_e       stage;
    word_t        pc;
    rv32i_instr_u instr;
    word_t        result;
    logic         fetch_pending;
    logic         mem_op;

    assign mem_op = i_decoded.is_load || i_decoded.is_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage         <= STAGE_FETCH;
            pc            <= i_reset_pc;
            instr         <= '0;
            fetch_pending <= 1'b0;
        end else begin
            case (stage)
                STAGE_FETCH: begin
                    // First cycle out of reset only arms the request
                    if (!fetch_pending) begin
                        fetch_pending <= 1'b1;
                    end else if (i_instr_mem_rsp.valid) begin
                        fetch_pending <= 1'b0;
                        instr         <= i_instr_mem_rsp.data;
                        stage         <= STAGE_DECODE;
                    end
                end
                STAGE_DECODE:  stage <= STAGE_EXECUTE;
                STAGE_EXECUTE: stage <= STAGE_MEM;
                STAGE_MEM: begin
                    if (!mem_op || i_data_mem_rsp.valid) begin
                        stage <= STAGE_WRITEBACK;
                    end
                end
                STAGE_WRITEBACK: begin
                    pc            <= pc + `CORE_INSTR_BYTES;
                    fetch_pending <= 1'b1;
                    stage         <= STAGE_FETCH;
                end
                default: stage <= STAGE_FETCH;
            endcase
        end
    end

    // Holds the ALU value, or the extended load data once it arrives
    always_ff @(posedge clk) begin
        if (stage == STAGE_EXECUTE) begin
            result <= i_exec_result;
        end else if (stage == STAGE_MEM && i_decoded.is_load && i_data_mem_rsp.valid) begin
            result <= i_load_data;
        end
    end

    always_comb begin
        o_instr_mem_req         = '0;
        o_instr_mem_req.valid   = fetch_pending;
        o_instr_mem_req.addr    = pc;
        o_instr_mem_req.do_read = fetch_pending ? '1 : '0;
    end

    assign o_instr     = instr;
    assign o_pc        = pc;
    assign o_result    = result;
    assign o_mem_stage = (stage == STAGE_MEM);
    assign o_wb_idx    = i_decoded.rd;
    assign o_wb_data   = result;
    assign o_wb_en     = (stage == STAGE_WRITEBACK) && i_decoded.writes_rd;

endmodule

/* source/instr_decoder.sv */
`include "core_cfg.svh"

module instr_decoder import core_pkg::*; (
    input  rv32i_instr_u i_instr,
    output decoded_t     o_decoded
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    op_e      op;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm;
    logic     is_load;
    logic     is_store;
    word_t    imm_i;
    word_t    imm_s;
    word_t    imm_u;
    word_t    shamt;

    assign imm_i = {{(`CORE_XLEN-`CORE_IMM_I_W){i_instr.i.imm[`CORE_IMM_I_W-1]}}, i_instr.i.imm};
    assign imm_s = {{(`CORE_XLEN-`CORE_IMM_I_W){i_instr.s.imm_hi[6]}},
                    i_instr.s.imm_hi, i_instr.s.imm_lo};
    assign imm_u = {i_instr.u.imm, {(`CORE_XLEN-`CORE_IMM_U_W){1'b0}}};
    assign shamt = {{(`CORE_XLEN-SHAMT_W){1'b0}}, i_instr.i.imm[SHAMT_W-1:0]};

    always_comb begin
        op  = OP_NONE;
        rs1 = '0;
        rs2 = '0;
        imm = '0;
        case (i_instr.r.opcode)
            OPC_OP: begin
                rs1 = i_instr.r.rs1;
                rs2 = i_instr.r.rs2;
                if (i_instr.r.funct7 == F7_BASE) begin
                    case (i_instr.r.funct3)
                        3'b000: op = OP_ADD;
                        3'b001: op = OP_SLL;
                        3'b010: op = OP_SLT;
                        3'b011: op = OP_SLTU;
                        3'b100: op = OP_XOR;
                        3'b101: op = OP_SRL;
                        3'b110: op = OP_OR;
                        default: op = OP_AND;
                    endcase
                end else if (i_instr.r.funct7 == F7_ALT) begin
                    // Only SUB and SRA use the alternate funct7
                    if (i_instr.r.funct3 == 3'b000) op = OP_SUB;
                    if (i_instr.r.funct3 == 3'b101) op = OP_SRA;
                end
            end
            OPC_OP_IMM: begin
                rs1 = i_instr.i.rs1;
                imm = imm_i;
                case (i_instr.i.funct3)
                    3'b000: op = OP_ADDI;
                    3'b010: op = OP_SLTI;
                    3'b011: op = OP_SLTIU;
                    3'b100: op = OP_XORI;
                    3'b110: op = OP_ORI;
                    3'b111: op = OP_ANDI;
                    3'b001: begin
                        imm = shamt;
                        if (i_instr.r.funct7 == F7_BASE) op = OP_SLLI;
                    end
                    default: begin
                        imm = shamt;
                        if (i_instr.r.funct7 == F7_BASE) op = OP_SRLI;
                        if (i_instr.r.funct7 == F7_ALT) op = OP_SRAI;
                    end
                endcase
            end
            OPC_LOAD: begin
                rs1 = i_instr.i.rs1;
                imm = imm_i;
                case (i_instr.i.funct3)
                    3'b000: op = OP_LB;
                    3'b001: op = OP_LH;
                    3'b010: op = OP_LW;
                    3'b100: op = OP_LBU;
                    3'b101: op = OP_LHU;
                    default: op = OP_NONE;
                endcase
            end
            OPC_STORE: begin
                rs1 = i_instr.s.rs1;
                rs2 = i_instr.s.rs2;
                imm = imm_s;
                case (i_instr.s.funct3)
                    3'b000: op = OP_SB;
                    3'b001: op = OP_SH;
                    3'b010: op = OP_SW;
                    default: op = OP_NONE;
                endcase
            end
            OPC_LUI: begin
                op  = OP_LUI;
                imm = imm_u;
            end
            OPC_AUIPC: begin
                op  = OP_AUIPC;
                imm = imm_u;
            end
            default: op = OP_NONE;
        endcase
    end

    assign is_load  = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    assign is_store = op inside {OP_SB, OP_SH, OP_SW};

    // rd sits at the same bits in every format that has one
    always_comb begin
        o_decoded.op        = op;
        o_decoded.rs1       = rs1;
        o_decoded.rs2       = rs2;
        o_decoded.rd        = i_instr.r.rd;
        o_decoded.imm       = imm;
        o_decoded.is_load   = is_load;
        o_decoded.is_store  = is_store;
        o_decoded.writes_rd = (op != OP_NONE) && !is_store;
    end

endmodule

/* source/register_file.sv */
`include "core_cfg.svh"

module register_file import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t i_rs1_idx,
    input  reg_idx_t i_rs2_idx,
    input  reg_idx_t i_wr_idx,
    input  word_t    i_wr_data,
    input  logic     i_wr_en,
    output word_t    o_rs1_data,
    output word_t    o_rs2_data
);

    word_t regs [`CORE_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && i_wr_idx != '0) begin
            regs[i_wr_idx] <= i_wr_data;
        end
    end

    // x0 reads as zero whatever the array holds
    always_ff @(posedge clk) begin
        o_rs1_data <= (i_rs1_idx == '0) ? '0 : regs[i_rs1_idx];
        o_rs2_data <= (i_rs2_idx == '0) ? '0 : regs[i_rs2_idx];
    end

endmodule

/* source/alu_exec.sv */
`include "core_cfg.svh"

module alu_exec import core_pkg::*; (
    input  decoded_t i_decoded,
    input  word_t    i_pc,
    input  word_t    i_rs1_data,
    input  word_t    i_rs2_data,
    output word_t    o_result
);

    localparam int SHAMT_W = $clog2(`CORE_XLEN);

    word_t              a;
    word_t              b;
    logic [SHAMT_W-1:0] shamt;
    logic               use_rs2;

    // R-type takes rs2, everything else the immediate
    assign use_rs2 = i_decoded.op inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
                                          OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND};
    assign a       = i_rs1_data;
    assign b       = use_rs2 ? i_rs2_data : i_decoded.imm;
    assign shamt   = b[SHAMT_W-1:0];

    always_comb begin
        case (i_decoded.op)
            OP_ADD, OP_ADDI:   o_result = a + b;
            OP_SUB:            o_result = a - b;
            OP_SLL, OP_SLLI:   o_result = a << shamt;
            OP_SRL, OP_SRLI:   o_result = a >> shamt;
            OP_SRA, OP_SRAI:   o_result = $signed(a) >>> shamt;
            OP_SLT, OP_SLTI:   o_result = word_t'($signed(a) < $signed(b));
            OP_SLTU, OP_SLTIU: o_result = word_t'(a < b);
            OP_XOR, OP_XORI:   o_result = a ^ b;
            OP_OR, OP_ORI:     o_result = a | b;
            OP_AND, OP_ANDI:   o_result = a & b;
            OP_LUI:            o_result = i_decoded.imm;
            OP_AUIPC:          o_result = i_pc + i_decoded.imm;
            // Effective address for every load and store
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW: o_result = a + i_decoded.imm;
            default:           o_result = '0;
        endcase
    end

endmodule

/* source/mem_access.sv */
`include "core_cfg.svh"

module mem_access import core_pkg::*; (
    input  logic     i_mem_stage,
    input  decoded_t i_decoded,
    input  word_t    i_addr,
    input  word_t    i_rs2_data,
    input  mem_rsp_t i_data_mem_rsp,
    output mem_req_t o_data_mem_req,
    output word_t    o_load_data
);

    localparam int OFS_W = $clog2(`CORE_BYTE_LANES);

    logic [OFS_W-1:0] offset;
    byte_mask_t       size_mask;
    byte_mask_t       lane_mask;
    word_t            lane_data;

    assign offset = i_addr[OFS_W-1:0];

    always_comb begin
        case (i_decoded.op)
            OP_LB, OP_LBU, OP_SB: size_mask = byte_mask_t'(4'b0001);
            OP_LH, OP_LHU, OP_SH: size_mask = byte_mask_t'(4'b0011);
            default:              size_mask = '1;
        endcase
    end

    assign lane_mask = size_mask << offset;

    always_comb begin
        o_data_mem_req.valid    = i_mem_stage && (i_decoded.is_load || i_decoded.is_store);
        o_data_mem_req.addr     = {i_addr[`CORE_XLEN-1:OFS_W], {OFS_W{1'b0}}};
        o_data_mem_req.do_read  = i_decoded.is_load ? lane_mask : '0;
        o_data_mem_req.do_write = i_decoded.is_store ? lane_mask : '0;
        o_data_mem_req.wdata    = i_rs2_data << {offset, 3'b000};
    end

    // Bring the addressed lanes down to bit 0, then extend
    assign lane_data = i_data_mem_rsp.data >> {offset, 3'b000};

    always_comb begin
        case (i_decoded.op)
            OP_LB:   o_load_data = {{(`CORE_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            OP_LH:   o_load_data = {{(`CORE_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            OP_LBU:  o_load_data = {{(`CORE_XLEN-8){1'b0}}, lane_data[7:0]};
            OP_LHU:  o_load_data = {{(`CORE_XLEN-16){1'b0}}, lane_data[15:0]};
            default: o_load_data = lane_data;
        endcase
    end

endmodule

/* source/core_top.sv */
module core_top import core_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  word_t    i_reset_pc,
    output mem_req_t o_instr_mem_req,
    input  mem_rsp_t i_instr_mem_rsp,
    output mem_req_t o_data_mem_req,
    input  mem_rsp_t i_data_mem_rsp
);

    rv32i_instr_u instr;
    decoded_t     decoded;
    word_t        pc;
    word_t        result;
    word_t        exec_result;
    word_t        load_data;
    word_t        rs1_data;
    word_t        rs2_data;
    logic         mem_stage;
    reg_idx_t     wb_idx;
    word_t        wb_data;
    logic         wb_en;

    core_control u_control (
        .clk             (clk),
        .reset           (reset),
        .i_reset_pc      (i_reset_pc),
        .i_instr_mem_rsp (i_instr_mem_rsp),
        .i_decoded       (decoded),
        .i_exec_result   (exec_result),
        .i_data_mem_rsp  (i_data_mem_rsp),
        .i_load_data     (load_data),
        .o_instr_mem_req (o_instr_mem_req),
        .o_instr         (instr),
        .o_pc            (pc),
        .o_result        (result),
        .o_mem_stage     (mem_stage),
        .o_wb_idx        (wb_idx),
        .o_wb_data       (wb_data),
        .o_wb_en         (wb_en)
    );

    instr_decoder u_decoder (
        .i_instr   (instr),
        .o_decoded (decoded)
    );

    // Indices come from the latched word, data is ready one cycle later
    register_file u_regfile (
        .clk        (clk),
        .reset      (reset),
        .i_rs1_idx  (decoded.rs1),
        .i_rs2_idx  (decoded.rs2),
        .i_wr_idx   (wb_idx),
        .i_wr_data  (wb_data),
        .i_wr_en    (wb_en),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    alu_exec u_alu (
        .i_decoded  (decoded),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (exec_result)
    );

    // Registered execute result doubles as the effective address
    mem_access u_mem (
        .i_mem_stage     (mem_stage),
        .i_decoded       (decoded),
        .i_addr          (result),
        .i_rs2_data      (rs2_data),
        .i_data_mem_rsp  (i_data_mem_rsp),
        .o_data_mem_req  (o_data_mem_req),
        .o_load_data     (load_data)
    );

endmodule

/* testbench/core_assert.sv */
module core_assert import core_pkg::*; (
    input logic     clk,
    input logic     reset,
    input mem_req_t i_instr_req,
    input mem_rsp_t i_instr_rsp,
    input mem_req_t i_data_req,
    input mem_rsp_t i_data_rsp
);

    timeunit 1ns;
    timeprecision 100ps;

    // Outputs settle one edge into reset
    logic reset_seen;

    // Number of failed properties so far
    int unsigned fail_count = 0;

    always_ff @(posedge clk) begin
        reset_seen <= reset;
    end

    a_instr_hold: assert property (@(posedge clk) disable iff (reset)
        i_instr_req.valid && !i_instr_rsp.valid |=> $stable(i_instr_req))
        else begin
            $error("instruction request changed while waiting for its response");
            fail_count++;
        end

    a_data_hold: assert property (@(posedge clk) disable iff (reset)
        i_data_req.valid && !i_data_rsp.valid |=> $stable(i_data_req))
        else begin
            $error("data request changed while waiting for its response");
            fail_count++;
        end

    a_one_port: assert property (@(posedge clk) disable iff (reset)
        !(i_instr_req.valid && i_data_req.valid))
        else begin
            $error("instruction and data requests valid together");
            fail_count++;
        end

    a_reset_idle: assert property (@(posedge clk)
        reset && reset_seen |-> !i_instr_req.valid && !i_data_req.valid)
        else begin
            $error("memory request valid during reset");
            fail_count++;
        end

endmodule

/* testbench/core_tb.sv */
module core_tb import core_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CLK_PERIOD   = 4;
    localparam int    RESET_CYCLES = 8;
    localparam int    NUM_INSTR    = 300;
    localparam int    MAX_DELAY    = 3;
    localparam int    TIMEOUT_NS   = NUM_INSTR * (5 + 2 * MAX_DELAY) * CLK_PERIOD * 2;
    localparam word_t RESET_PC     = 32'h0000_0400;
    localparam word_t DATA_BASE    = 32'h0001_0000;
    localparam word_t SEED         = 32'h59ed_ea0d;

    logic     clk;
    logic     reset;
    word_t    reset_pc;
    mem_req_t instr_req;
    mem_rsp_t instr_rsp;
    mem_req_t data_req;
    mem_rsp_t data_rsp;

    // Reference model state
    word_t lfsr_state;
    word_t model_pc;
    word_t mregs [32];
    word_t imem [NUM_INSTR];
    word_t dmem [word_t];

    core_top u_dut (
        .clk             (clk),
        .reset           (reset),
        .i_reset_pc      (reset_pc),
        .o_instr_mem_req (instr_req),
        .i_instr_mem_rsp (instr_rsp),
        .o_data_mem_req  (data_req),
        .i_data_mem_rsp  (data_rsp)
    );

    bind core_top core_assert u_assert (
        .clk         (clk),
        .reset       (reset),
        .i_instr_req (o_instr_mem_req),
        .i_instr_rsp (i_instr_mem_rsp),
        .i_data_req  (o_data_mem_req),
        .i_data_rsp  (i_data_mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        report_failure("watchdog expired before the program finished");
    end

    // Port properties checked in the bound module
    initial begin : assertion_monitor
        wait (u_dut.u_assert.fail_count != 0);
        report_failure("a memory port assertion failed");
    end

    // Taps 32, 22, 2, 1
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    // Offsets aligned to the access size keep every address aligned
    function automatic logic [11:0] align_offset(input logic [11:0] imm, input logic [1:0] width);
        if (width == 2'd0) return imm;
        if (width == 2'd1) return {imm[11:1], 1'b0};
        return {imm[11:2], 2'b00};
    endfunction

    function automatic word_t random_instr();
        logic [2:0]  kind;
        logic [2:0]  f3;
        logic [1:0]  width;
        logic [11:0] imm;
        logic        alt;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        kind  = 3'(rand_bits(3));
        f3    = 3'(rand_bits(3));
        rd    = reg_idx_t'(rand_bits(5));
        rs1   = reg_idx_t'(rand_bits(5));
        rs2   = reg_idx_t'(rand_bits(5));
        imm   = 12'(rand_bits(12));
        alt   = rand_bits(1) != 0;
        width = 2'(rand_bits(2));
        // x1 holds the data base and stays untouched
        if (rd == 5'd1) rd = '0;
        if (width == 2'd3) width = 2'd2;
        case (kind)
            3'd0, 3'd1: begin
                return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00,
                             rs2, rs1, f3, rd, OPC_OP);
            end
            3'd2, 3'd3: begin
                if (f3 == 3'd1) imm = {7'h00, imm[4:0]};
                if (f3 == 3'd5) imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            3'd4: return {20'(rand_bits(20)), rd, alt ? OPC_AUIPC : OPC_LUI};
            3'd5: begin
                return enc_i(align_offset(imm, width), 5'd1,
                             {alt && width != 2'd2, width}, rd, OPC_LOAD);
            end
            default: return enc_s(align_offset(imm, width), rs2, 5'd1, {1'b0, width});
        endcase
    endfunction

    task automatic build_program();
        imem[0] = {DATA_BASE[31:12], 5'd1, 7'b0110111};
        for (int n = 1; n < NUM_INSTR - 32; n++) begin
            imem[n] = random_instr();
        end
        // Closing sweep exposes every register, x0 included
        for (int r = 0; r < 32; r++) begin
            imem[NUM_INSTR - 32 + r] = enc_s(12'(r * 4), reg_idx_t'(r), 5'd1, 3'b010);
        end
    endtask

    task automatic preload_data();
        for (int k = -512; k < 512; k++) begin
            dmem[DATA_BASE + word_t'(k * 4)] = rand_bits(32);
        end
    endtask

    function automatic word_t lane_bits(input byte_mask_t mask);
        return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    endfunction

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return word_t'($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // Executes one instruction and gives the data access it must make
    task automatic model_step(input word_t instr, output logic is_mem,
                              output mem_req_t exp_req, output word_t rsp_data);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [1:0] ofs;
        reg_idx_t   rd;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      addr;
        word_t      lane;
        word_t      value;
        byte_mask_t mask;
        logic       writes;
        opc      = instr[6:0];
        f3       = instr[14:12];
        rd       = instr[11:7];
        a        = mregs[instr[19:15]];
        b        = mregs[instr[24:20]];
        imm_i    = {{20{instr[31]}}, instr[31:20]};
        imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        addr     = a + ((opc == OPC_STORE) ? imm_s : imm_i);
        ofs      = addr[1:0];
        mask     = (f3[1] ? 4'b1111 : (f3[0] ? 4'b0011 : 4'b0001)) << ofs;
        is_mem   = 1'b0;
        exp_req  = '0;
        rsp_data = '0;
        value    = '0;
        writes   = 1'b1;
        case (opc)
            OPC_OP:     value = alu_ref(f3, instr[30], a, b);
            OPC_OP_IMM: value = alu_ref(f3, instr[30] && f3 == 3'd5, a, imm_i);
            OPC_LUI:    value = {instr[31:12], 12'b0};
            OPC_AUIPC:  value = model_pc + {instr[31:12], 12'b0};
            OPC_LOAD: begin
                is_mem          = 1'b1;
                exp_req.do_read = mask;
                rsp_data        = dmem[{addr[31:2], 2'b00}];
                lane            = rsp_data >> (8 * ofs);
                case (f3)
                    3'd0:    value = {{24{lane[7]}}, lane[7:0]};
                    3'd1:    value = {{16{lane[15]}}, lane[15:0]};
                    3'd4:    value = {24'b0, lane[7:0]};
                    3'd5:    value = {16'b0, lane[15:0]};
                    default: value = lane;
                endcase
            end
            OPC_STORE: begin
                is_mem           = 1'b1;
                writes           = 1'b0;
                exp_req.do_write = mask;
                exp_req.wdata    = b << (8 * ofs);
                dmem[{addr[31:2], 2'b00}] = (dmem[{addr[31:2], 2'b00}] & ~lane_bits(mask))
                                            | (exp_req.wdata & lane_bits(mask));
            end
            default: writes = 1'b0;
        endcase
        exp_req.valid = is_mem;
        exp_req.addr  = {addr[31:2], 2'b00};
        if (writes && rd != '0) mregs[rd] = value;
        model_pc = model_pc + 32'd4;
    endtask

    task automatic wait_for_request(input logic data_port);
        while (!(data_port ? data_req.valid : instr_req.valid)) begin
            if (data_port ? instr_req.valid : data_req.valid) begin
                report_failure("request raised on the wrong memory port");
            end
            @(posedge clk);
            #1;
        end
    endtask

    // Random wait, then a one-cycle response strobe
    task automatic respond(input logic data_port, input word_t data);
        int unsigned delay;
        delay = rand_bits(2);
        repeat (delay) begin
            @(posedge clk);
            #1;
        end
        if (data_port) begin
            data_rsp.valid = 1'b1;
            data_rsp.data  = data;
        end else begin
            instr_rsp.valid = 1'b1;
            instr_rsp.data  = data;
        end
        @(posedge clk);
        #1;
        instr_rsp = '0;
        data_rsp  = '0;
    endtask

    initial begin : stimulus
        logic     is_mem;
        mem_req_t exp_req;
        word_t    rsp_data;
        reset      = 1'b1;
        reset_pc   = RESET_PC;
        instr_rsp  = '0;
        data_rsp   = '0;
        lfsr_state = SEED;
        model_pc   = RESET_PC;
        for (int r = 0; r < 32; r++) begin
            mregs[r] = '0;
        end
        build_program();
        preload_data();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < NUM_INSTR; n++) begin
            wait_for_request(1'b0);
            check_value("instr_req.addr", instr_req.addr, model_pc);
            check_value("instr_req.do_read", word_t'(instr_req.do_read), 32'hf);
            check_value("instr_req.do_write", word_t'(instr_req.do_write), 32'h0);
            check_value("instr_req.wdata", instr_req.wdata, 32'h0);
            model_step(imem[n], is_mem, exp_req, rsp_data);
            respond(1'b0, imem[n]);
            if (is_mem) begin
                wait_for_request(1'b1);
                check_value("data_req.addr", data_req.addr, exp_req.addr);
                check_value("data_req.do_read", word_t'(data_req.do_read),
                            word_t'(exp_req.do_read));
                check_value("data_req.do_write", word_t'(data_req.do_write),
                            word_t'(exp_req.do_write));
                check_value("data_req.wdata", data_req.wdata & lane_bits(exp_req.do_write),
                            exp_req.wdata & lane_bits(exp_req.do_write));
                respond(1'b1, rsp_data);
            end
        end
        if (u_dut.u_assert.fail_count != 0) begin
            report_failure("a memory port assertion failed");
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* flist.f */
+incdir+source
source/core_pkg.sv
source/core_control.sv
source/instr_decoder.sv
source/register_file.sv
source/alu_exec.sv
source/mem_access.sv
source/core_top.sv
testbench/core_assert.sv
testbench/core_tb.sv
